/* source/fetch_defs.svh */
// fetch unit configuration macros for width, reset vector, RVC support and the NOP word
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

// integer register and address width, RV32 only
`define XLEN 32

// first fetch address after reset
`define RESET_VECTOR 32'h80000000

//////////////////////////////////////////////////////////////////////
// ISA options
//////////////////////////////////////////////////////////////////////

// 1 allows compressed code on halfword boundaries
// 0 demands word aligned targets
`define C_SUPPORTED 1

// addi x0, x0, 0 is loaded into a flushed stage
`define NOP_INSTR 32'h00000013

`endif

/* source/fetch_pkg.sv */
// shared types of the instruction fetch unit
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // basic words
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [31:0]      instr_t;
  typedef logic [15:0]      half_t;

  // stall and flush levels from the hazard unit
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } hazard_s;

  // change of flow requests
  // execute stage branches and privileged unit traps or returns
  typedef struct packed {
    logic  branchE;
    addr_t branchTargetE;
    logic  privChangeM;
    addr_t privNextPcM;
  } redirect_s;

  // aligned fetch record handed to the D stage
  typedef struct packed {
    instr_t instrF;
    addr_t  pcF;
    addr_t  pcPlusF;
    logic   compressedF;
  } fetchOut_s;

  // one RVC halfword seen in two formats
  typedef union packed {
    struct packed {
      logic [2:0] funct3;
      logic       immHi;
      logic [4:0] rd;
      logic [4:0] immLo;
      logic [1:0] op;
    } ci;
    struct packed {
      logic [3:0] funct4;
      logic [4:0] rd;
      logic [4:0] rs2;
      logic [1:0] op;
    } cr;
  } cInstr_u;

endpackage

`default_nettype wire

/* source/pcLogic.sv */
// program counter with next-PC priority, PC+2/4 increment and branch target alignment check
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defs.svh"

module pcLogic (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stallF,
  input  fetch_pkg::redirect_s redirect,
  input  fetch_pkg::instr_t    instrF,
  output fetch_pkg::addr_t     pcF,
  output fetch_pkg::addr_t     pcPlusF,
  output fetch_pkg::addr_t     unalignedNextPc,
  output logic                 misalignedE
);

  fetch_pkg::addr_t pcNextF;
  logic [`XLEN-3:0] pcUpperPlus;
  logic             compressed;
  logic             misaligned;

  //////////////////////////////////////////////////////////////////////
  // next PC selection
  //////////////////////////////////////////////////////////////////////

  // traps and returns beat branches, branches beat sequential flow
  always_comb begin
    if (redirect.privChangeM) begin
      unalignedNextPc = redirect.privNextPcM;
    end else if (redirect.branchE) begin
      unalignedNextPc = redirect.branchTargetE;
    end else begin
      unalignedNextPc = pcPlusF;
    end
  end

  // instructions start on halfwords so bit 0 is dropped
  assign pcNextF = {unalignedNextPc[`XLEN-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= `RESET_VECTOR;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequential increment
  //////////////////////////////////////////////////////////////////////

  // low bits other than 11 mark a 16-bit instruction
  assign compressed  = (instrF[1:0] != 2'b11);
  // word part plus one, shared by both step sizes
  assign pcUpperPlus = pcF[`XLEN-1:2] + 1'b1;

  always_comb begin
    if (compressed) begin
      // upper halfword steps into the next word
      if (pcF[1]) pcPlusF = {pcUpperPlus, 2'b00};
      else        pcPlusF = {pcF[`XLEN-1:2], 2'b10};
    end else begin
      pcPlusF = {pcUpperPlus, pcF[1:0]};
    end
  end

  // with RVC only odd targets fault, without it any non word target does
  always_comb begin
    if (`C_SUPPORTED) misaligned = unalignedNextPc[0];
    else              misaligned = |unalignedNextPc[1:0];
  end

  // only taken branches report, the M stage register delays it
  assign misalignedE = misaligned & redirect.branchE;

endmodule

`default_nettype wire

/* source/instrAlign.sv */
// halfword alignment of the fetched word into the fetch record
`default_nettype none
`timescale 1ns/1ps

module instrAlign (
  input  fetch_pkg::addr_t     pcF,
  input  fetch_pkg::instr_t    instrIn,
  input  fetch_pkg::half_t     nextHalf,
  input  fetch_pkg::addr_t     pcPlusF,
  output fetch_pkg::fetchOut_s fetch
);

  fetch_pkg::instr_t instrF;

  // pc on the upper halfword
  // low half of the next word completes a straddling 32-bit instruction
  // a 16-bit one just ignores those upper bits
  always_comb begin
    if (pcF[1]) begin
      instrF = {nextHalf, instrIn[31:16]};
    end else begin
      instrF = instrIn;
    end
  end

  // pack the record for the D stage
  always_comb begin
    fetch.instrF      = instrF;
    fetch.pcF         = pcF;
    // link address, computed by pcLogic from instrF
    fetch.pcPlusF     = pcPlusF;
    // 16-bit when the opcode low bits are not 11
    fetch.compressedF = (instrF[1:0] != 2'b11);
  end

endmodule

`default_nettype wire

/* source/decompress.sv */
// expansion of the supported RVC subset to base RV32I instructions
`default_nettype none
`timescale 1ns/1ps

module decompress (
  input  fetch_pkg::instr_t instrRawD,
  output fetch_pkg::instr_t instrD,
  output logic              illegalCompD
);

  fetch_pkg::cInstr_u c;
  fetch_pkg::half_t   h;
  logic [4:0]         rdP;
  logic [4:0]         rs1P;
  logic [11:0]        ciImm;
  logic [19:0]        luiImm;
  logic [11:0]        lwImm;
  logic [19:0]        jImm;
  logic [12:1]        bImm;

  // same halfword, read through the union and as plain bits
  assign c = instrRawD[15:0];
  assign h = instrRawD[15:0];

  // three bit register fields select x8 to x15
  assign rdP  = {2'b01, h[4:2]};
  assign rs1P = {2'b01, h[9:7]};

  //////////////////////////////////////////////////////////////////////
  // immediates
  //////////////////////////////////////////////////////////////////////

  // CI six bit immediate, sign extended
  assign ciImm  = {{6{c.ci.immHi}}, c.ci.immHi, c.ci.immLo};
  assign luiImm = {{14{c.ci.immHi}}, c.ci.immHi, c.ci.immLo};
  // word offset for c.lw and c.sw, zero extended
  assign lwImm  = {5'b0, h[5], h[12:10], h[6], 2'b00};
  // c.j offset in jal field order imm[20|10:1|11|19:12]
  assign jImm   = {h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3],
                   h[12], {8{h[12]}}};
  // c.beqz/c.bnez offset, sign extended from bit 8
  assign bImm   = {{5{h[12]}}, h[6:5], h[2], h[11:10], h[4:3]};

  //////////////////////////////////////////////////////////////////////
  // expansion
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    instrD       = instrRawD;
    illegalCompD = 1'b0;
    if (instrRawD[1:0] != 2'b11) begin
      // unsupported halfwords stay visible zero extended for the trap value
      instrD       = {16'b0, h};
      illegalCompD = 1'b1;
      case (c.ci.op)
        2'b00: begin
          case (c.ci.funct3)
            // c.lw
            3'b010: begin
              instrD       = {lwImm, rs1P, 3'b010, rdP, 7'b0000011};
              illegalCompD = 1'b0;
            end
            // c.sw
            3'b110: begin
              instrD       = {lwImm[11:5], rdP, rs1P, 3'b010, lwImm[4:0], 7'b0100011};
              illegalCompD = 1'b0;
            end
            // all zeros lands here too
            default: ;
          endcase
        end
        2'b01: begin
          case (c.ci.funct3)
            // c.addi and c.nop
            3'b000: begin
              instrD       = {ciImm, c.ci.rd, 3'b000, c.ci.rd, 7'b0010011};
              illegalCompD = 1'b0;
            end
            // c.li is addi from x0
            3'b010: begin
              instrD       = {ciImm, 5'b0, 3'b000, c.ci.rd, 7'b0010011};
              illegalCompD = 1'b0;
            end
            // c.lui, rd of x2 is c.addi16sp which is not supported
            3'b011: begin
              if (c.ci.rd != 5'd2 && ciImm != 12'b0) begin
                instrD       = {luiImm, c.ci.rd, 7'b0110111};
                illegalCompD = 1'b0;
              end
            end
            // c.j is jal x0
            3'b101: begin
              instrD       = {jImm, 5'b0, 7'b1101111};
              illegalCompD = 1'b0;
            end
            // c.beqz and c.bnez compare against x0, bit 13 picks bne
            3'b110, 3'b111: begin
              instrD       = {bImm[12], bImm[10:5], 5'b0, rs1P, 2'b00, h[13],
                              bImm[4:1], bImm[11], 7'b1100011};
              illegalCompD = 1'b0;
            end
            default: ;
          endcase
        end
        2'b10: begin
          if (c.ci.funct3 == 3'b100) begin
            if (c.cr.funct4 == 4'b1000) begin
              if (c.cr.rs2 == 5'd0) begin
                // c.jr, rs1 of x0 is reserved
                if (c.cr.rd != 5'd0) begin
                  instrD       = {12'b0, c.cr.rd, 3'b000, 5'b0, 7'b1100111};
                  illegalCompD = 1'b0;
                end
              end else begin
                // c.mv is add from x0
                instrD       = {7'b0, c.cr.rs2, 5'b0, 3'b000, c.cr.rd, 7'b0110011};
                illegalCompD = 1'b0;
              end
            end else if (c.cr.rs2 != 5'd0) begin
              // c.add, ebreak and jalr share this funct4 with rs2 of zero
              instrD       = {7'b0, c.cr.rs2, c.cr.rd, 3'b000, c.cr.rd, 7'b0110011};
              illegalCompD = 1'b0;
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/stageRegs.sv */
// D/E/M/W pipeline registers with stall and flush and the M stage fault register
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defs.svh"

module stageRegs (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::hazard_s   hazard,
  input  fetch_pkg::fetchOut_s fetch,
  input  logic                 misalignedE,
  input  fetch_pkg::addr_t     unalignedNextPc,
  output fetch_pkg::instr_t    instrRawD,
  input  fetch_pkg::instr_t    instrDExp,
  output fetch_pkg::instr_t    instrM,
  output fetch_pkg::addr_t     pcE,
  output fetch_pkg::addr_t     pcM,
  output fetch_pkg::addr_t     pcLinkW,
  output logic                 instrMisalignedFaultM,
  output fetch_pkg::addr_t     instrMisalignedAdrM
);

  // contents of one pipeline stage
  typedef struct packed {
    fetch_pkg::instr_t instr;
    fetch_pkg::addr_t  pc;
    fetch_pkg::addr_t  link;
  } stage_s;

  localparam stage_s stageIdle = '{instr: `NOP_INSTR, pc: '0, link: '0};

  stage_s inD;
  stage_s inE;
  stage_s stD;
  stage_s stE;
  stage_s stM;
  stage_s stW;

  // stall holds, flush turns the instruction into a NOP
  function automatic stage_s advance(input stage_s cur, input stage_s nxt,
                                     input logic stall, input logic flush);
    stage_s res;
    res = nxt;
    if (flush) res.instr = `NOP_INSTR;
    if (stall) res = cur;
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stage inputs
  //////////////////////////////////////////////////////////////////////

  // flush of D also drops the pc
  assign inD = '{instr: fetch.instrF,
                 pc:    (hazard.flushD ? '0 : fetch.pcF),
                 link:  fetch.pcPlusF};
  // E gets the expanded instruction
  assign inE = '{instr: instrDExp, pc: stD.pc, link: stD.link};

  always_ff @(posedge clk) begin
    if (rst) begin
      stD <= stageIdle;
      stE <= stageIdle;
      stM <= stageIdle;
      stW <= stageIdle;
    end else begin
      stD <= advance(stD, inD, hazard.stallD, hazard.flushD);
      stE <= advance(stE, inE, hazard.stallE, hazard.flushE);
      stM <= advance(stM, stE, hazard.stallM, hazard.flushM);
      stW <= advance(stW, stM, hazard.stallW, hazard.flushW);
    end
  end

  // branch target fault moves from E into M
  always_ff @(posedge clk) begin
    if (rst) instrMisalignedFaultM <= 1'b0;
    else if (!hazard.stallM) instrMisalignedFaultM <= misalignedE;
  end

  always_ff @(posedge clk) begin
    if (!hazard.stallM) instrMisalignedAdrM <= unalignedNextPc;
  end

  assign instrRawD = stD.instr;
  assign pcE       = stE.pc;
  assign instrM    = stM.instr;
  assign pcM       = stM.pc;
  assign pcLinkW   = stW.link;

endmodule

`default_nettype wire

/* source/ifu.sv */
// instruction fetch unit top level joining PC logic, alignment, decompression and stages
`default_nettype none
`timescale 1ns/1ps

module ifu (
  input  logic                 clk,
  input  logic                 rst,
  // hazard unit
  input  fetch_pkg::hazard_s   hazard,
  // execute and privileged units
  input  fetch_pkg::redirect_s redirect,
  // instruction memory
  input  fetch_pkg::instr_t    instrIn,
  input  fetch_pkg::half_t     nextHalf,
  // base decoder verdict
  input  logic                 illegalBaseD,
  output fetch_pkg::addr_t     pcF,
  output fetch_pkg::instr_t    instrD,
  output fetch_pkg::instr_t    instrM,
  output fetch_pkg::addr_t     pcE,
  output fetch_pkg::addr_t     pcM,
  output fetch_pkg::addr_t     pcLinkW,
  output logic                 illegalInstrD,
  output logic                 instrMisalignedFaultM,
  output fetch_pkg::addr_t     instrMisalignedAdrM
);

  fetch_pkg::fetchOut_s fetch;
  fetch_pkg::addr_t     pcPlusF;
  fetch_pkg::addr_t     unalignedNextPc;
  fetch_pkg::instr_t    instrRawD;
  logic                 misalignedE;
  logic                 illegalCompD;

  //////////////////////////////////////////////////////////////////////
  // fetch stage
  //////////////////////////////////////////////////////////////////////

  pcLogic pcLogic (
    .clk            (clk),
    .rst            (rst),
    .stallF         (hazard.stallF),
    .redirect       (redirect),
    .instrF         (fetch.instrF),
    .pcF            (pcF),
    .pcPlusF        (pcPlusF),
    .unalignedNextPc(unalignedNextPc),
    .misalignedE    (misalignedE)
  );

  instrAlign instrAlign (
    .pcF     (pcF),
    .instrIn (instrIn),
    .nextHalf(nextHalf),
    .pcPlusF (pcPlusF),
    .fetch   (fetch)
  );

  //////////////////////////////////////////////////////////////////////
  // D stage onwards
  //////////////////////////////////////////////////////////////////////

  stageRegs stageRegs (
    .clk                  (clk),
    .rst                  (rst),
    .hazard               (hazard),
    .fetch                (fetch),
    .misalignedE          (misalignedE),
    .unalignedNextPc      (unalignedNextPc),
    .instrRawD            (instrRawD),
    .instrDExp            (instrD),
    .instrM               (instrM),
    .pcE                  (pcE),
    .pcM                  (pcM),
    .pcLinkW              (pcLinkW),
    .instrMisalignedFaultM(instrMisalignedFaultM),
    .instrMisalignedAdrM  (instrMisalignedAdrM)
  );

  decompress decompress (
    .instrRawD   (instrRawD),
    .instrD      (instrD),
    .illegalCompD(illegalCompD)
  );

  // bad 32-bit or bad 16-bit encoding
  assign illegalInstrD = illegalBaseD | illegalCompD;

endmodule

`default_nettype wire

/* bench/ifu_sva.sv */
// bound assertions on fetch unit reset, flush and trap redirects
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defs.svh"

module ifu_sva (
  input logic                 clk,
  input logic                 rst,
  input fetch_pkg::hazard_s   hazard,
  input fetch_pkg::redirect_s redirect,
  input fetch_pkg::addr_t     pcF,
  input fetch_pkg::instr_t    instrD,
  input logic                 instrMisalignedFaultM
);

  // a trap or return lands on its target with bit 0 dropped
  trapLandsOnTarget: assert property (@(posedge clk) disable iff (rst)
    redirect.privChangeM && !hazard.stallF |=>
      pcF == {$past(redirect.privNextPcM[`XLEN-1:1]), 1'b0})
    else $error("pcF missed the trap target");

  // a flushed D stage shows the NOP one cycle later
  flushGivesNop: assert property (@(posedge clk) disable iff (rst)
    hazard.flushD && !hazard.stallD |=> instrD == `NOP_INSTR)
    else $error("flushed D stage does not hold a NOP");

  // no fault comes out of a reset cycle
  faultLowInReset: assert property (@(posedge clk) rst |=> !instrMisalignedFaultM)
    else $error("misaligned fault set during reset");

endmodule

bind ifu ifu_sva ifuChecks (
  .clk                  (clk),
  .rst                  (rst),
  .hazard               (hazard),
  .redirect             (redirect),
  .pcF                  (pcF),
  .instrD               (instrD),
  .instrMisalignedFaultM(instrMisalignedFaultM)
);

`default_nettype wire

/* bench/ifu_tb.sv */
// testbench for the fetch unit with memory model, reference pipeline and watchdog
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defs.svh"

module ifu_tb;

  typedef struct packed {
    fetch_pkg::instr_t instr;
    fetch_pkg::addr_t  pc;
    fetch_pkg::addr_t  link;
    logic              ill;
  } mstage_s;

  logic clk, rst, illegalBaseD, illegalInstrD, instrMisalignedFaultM, baseNow, loaded;
  fetch_pkg::hazard_s   hazard;
  fetch_pkg::redirect_s redirect;
  fetch_pkg::instr_t    instrIn, nextWord, instrD, instrM;
  fetch_pkg::half_t     nextHalf;
  fetch_pkg::addr_t     pcF, pcE, pcM, pcLinkW, instrMisalignedAdrM, mPc, mAdr;
  fetch_pkg::instr_t    mem [0:255];
  mstage_s              mD, mE, mM, mW;
  logic                 mFault;
  fetch_pkg::half_t     dHalf[$];
  fetch_pkg::instr_t    dExp[$];
  logic                 dIll[$];
  int                   bOff[$], bFlag[$];
  fetch_pkg::addr_t     bTgt[$];
  int                   errs, checks, testNo, testsOk, errsAtStart, nRec;
  integer               seed;

  ifu DUT (.*);

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////

  // unloaded words are addi x0 with an immediate folded from the address
  function automatic fetch_pkg::instr_t fillWord(input fetch_pkg::addr_t a);
    logic [11:0] imm;
    imm = a[31:20] ^ a[19:8] ^ {a[7:0], 4'h0};
    return {imm, 5'd0, 3'd0, 5'd0, 7'h13};
  endfunction

  function automatic fetch_pkg::instr_t fetchWord(input fetch_pkg::addr_t a);
    fetch_pkg::addr_t off;
    off = a - `RESET_VECTOR;
    if (off < 1024) return mem[off[9:2]];
    return fillWord(a);
  endfunction

  always_comb begin
    instrIn  = fetchWord(pcF);
    nextWord = fetchWord(pcF + 4);
    nextHalf = nextWord[15:0];
  end

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  task automatic checkAddr(input string name, input fetch_pkg::addr_t got,
                           input fetch_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("Error %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkInstr(input string name, input fetch_pkg::instr_t got,
                            input fetch_pkg::instr_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("Error %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("Error %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compareAll();
    checkAddr("pcF", pcF, mPc);
    checkInstr("instrD", instrD, mD.instr);
    checkBit("illegalInstrD", illegalInstrD, mD.ill | baseNow);
    checkAddr("pcE", pcE, mE.pc);
    checkInstr("instrM", instrM, mM.instr);
    checkAddr("pcM", pcM, mM.pc);
    checkAddr("pcLinkW", pcLinkW, mW.link);
    checkBit("instrMisalignedFaultM", instrMisalignedFaultM, mFault);
    if (mFault) checkAddr("instrMisalignedAdrM", instrMisalignedAdrM, mAdr);
  endtask

  ////////////////////////////////////////////////////////////////////
  // reference pipeline
  ////////////////////////////////////////////////////////////////////

  // expansion comes from the D records, 32-bit words pass unchanged
  task automatic expand(input fetch_pkg::instr_t fi, output fetch_pkg::instr_t exp,
                        output logic ill);
    exp = fi;
    ill = 1'b0;
    if (fi[1:0] != 2'b11) begin
      ill = 1'bx;
      foreach (dHalf[i]) if (dHalf[i] == fi[15:0]) begin
        exp = dExp[i];
        ill = dIll[i];
      end
      if (ill === 1'bx) begin
        errs++;
        $display("no expected expansion for halfword %h at %0t", fi[15:0], $time);
        ill = 1'b0;
      end
    end
  endtask

  function automatic mstage_s flushed(input mstage_s s, input logic flush);
    mstage_s r;
    r = s;
    if (flush) begin
      r.instr = `NOP_INSTR;
      r.ill   = 1'b0;
    end
    return r;
  endfunction

  task automatic advanceModel(input fetch_pkg::hazard_s hz, input fetch_pkg::redirect_s rd);
    fetch_pkg::instr_t w0, w1, fi;
    fetch_pkg::addr_t  unal;
    mstage_s           fD;
    w0 = fetchWord(mPc);
    w1 = fetchWord(mPc + 4);
    // straddling word takes its top half from the next word
    fi = mPc[1] ? {w1[15:0], w0[31:16]} : w0;
    fD.link = mPc + ((fi[1:0] == 2'b11) ? 4 : 2);
    fD.pc = hz.flushD ? '0 : mPc;
    fD.instr = `NOP_INSTR;
    fD.ill = 1'b0;
    // a held or squashed fetch never reaches decode
    if (!hz.stallD && !hz.flushD) expand(fi, fD.instr, fD.ill);
    if (rd.privChangeM) unal = rd.privNextPcM;
    else if (rd.branchE) unal = rd.branchTargetE;
    else unal = fD.link;
    if (!hz.stallM) begin
      mFault = rd.branchE && (`C_SUPPORTED ? unal[0] : |unal[1:0]);
      mAdr   = unal;
    end
    // oldest stage first so each one sees its predecessor's old value
    if (!hz.stallW) mW = flushed(mM, hz.flushW);
    if (!hz.stallM) mM = flushed(mE, hz.flushM);
    if (!hz.stallE) mE = flushed(mD, hz.flushE);
    if (!hz.stallD) mD = flushed(fD, hz.flushD);
    if (!hz.stallF) mPc = {unal[31:1], 1'b0};
  endtask

  // compare at the falling edge, then drive the next inputs
  task automatic runCycle(input fetch_pkg::hazard_s hz, input fetch_pkg::redirect_s rd,
                          input logic base);
    @(negedge clk);
    compareAll();
    hazard       = hz;
    redirect     = rd;
    illegalBaseD = base;
    baseNow      = base;
    advanceModel(hz, rd);
  endtask

  task automatic endTest(input string name);
    testNo++;
    if (errs == errsAtStart) testsOk++;
    $display("test %0d %s: %s with %0d errors", testNo, name,
             (errs == errsAtStart) ? "ok" : "FAILED", errs - errsAtStart);
    errsAtStart = errs;
  endtask

  ////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin
    wait (loaded);
    repeat (40 * nRec + 200) @(posedge clk);
    $display("watchdog expired before the tests ended");
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int                   fd, code, a, b, c;
    byte                  kind;
    string                line;
    fetch_pkg::redirect_s rd;
    fetch_pkg::hazard_s   hz;
    logic [31:0]          r;
    clk = 0;
    rst = 1;
    hazard = '0;
    redirect = '0;
    illegalBaseD = 0;
    baseNow = 0;
    loaded = 0;
    seed = 85;
    errs = 0;
    checks = 0;
    testNo = 0;
    testsOk = 0;
    errsAtStart = 0;
    nRec = 0;
    mPc = `RESET_VECTOR;
    mD = '{instr: `NOP_INSTR, pc: '0, link: '0, ill: 1'b0};
    mE = mD;
    mM = mD;
    mW = mD;
    mFault = 0;
    mAdr = '0;
    for (int i = 0; i < 256; i++) mem[i] = fillWord(`RESET_VECTOR + 4 * i);
    fd = $fopen("bench/ifu_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file");
      $display("tests failed");
      $finish;
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%c %h %h %h", kind, a, b, c);
        nRec++;
        if (kind == "M") mem[(a - `RESET_VECTOR) >> 2] = b;
        if (kind == "D") begin
          dHalf.push_back(a[15:0]);
          dExp.push_back(b);
          dIll.push_back(c[0]);
        end
        if (kind == "B") begin
          bOff.push_back(a);
          bTgt.push_back(b);
          bFlag.push_back(c);
        end
      end
    end
    $fclose(fd);
    loaded = 1;

    repeat (5) @(negedge clk);
    compareAll();
    rst = 0;
    advanceModel('0, '0);
    endTest("reset state");

    repeat (24) runCycle('0, '0, 1'b0);
    endTest("sequential mixed fetch");

    // each halfword is placed in a scratch word and reached by a branch
    foreach (dHalf[i]) begin
      mem[128] = {16'h0001, dHalf[i]};
      rd = '0;
      rd.branchE = 1;
      rd.branchTargetE = `RESET_VECTOR + 32'h200;
      runCycle('0, rd, 1'b0);
      runCycle('0, '0, 1'b0);
      runCycle('0, '0, 1'b1);
      runCycle('0, '0, 1'b0);
      runCycle('0, '0, 1'b0);
    end
    endTest("decompression and illegal flag");

    foreach (bOff[i]) begin
      repeat (bOff[i]) runCycle('0, '0, 1'b0);
      rd = '0;
      rd.branchE = (bFlag[i] != 1);
      rd.branchTargetE = (bFlag[i] == 2) ? bTgt[i] ^ 32'h40 : bTgt[i];
      rd.privChangeM = (bFlag[i] != 0);
      rd.privNextPcM = bTgt[i];
      runCycle('0, rd, 1'b0);
      // the fetch at a faulting target is squashed in D
      hz = '0;
      hz.flushD = bTgt[i][0];
      runCycle(hz, '0, 1'b0);
    end
    endTest("redirect priority and misaligned fault");

    repeat (80) begin
      r = $random(seed);
      hz = {r[1:0] == 0, r[3:2] == 0, r[5:4] == 0, r[7:6] == 0, r[9:8] == 0,
            r[11:10] == 0, r[13:12] == 0, r[15:14] == 0, r[17:16] == 0};
      runCycle(hz, '0, r[20]);
    end
    repeat (4) runCycle('0, '0, 1'b0);
    endTest("random stalls and flushes");

    $display("%0d of %0d tests ok, %0d checks, %0d errors", testsOk, testNo, checks, errs);
    if (errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ifu.f */
+incdir+source
source/fetch_pkg.sv
source/pcLogic.sv
source/instrAlign.sv
source/decompress.sv
source/stageRegs.sv
source/ifu.sv
bench/ifu_sva.sv
bench/ifu_tb.sv

/* Bender.yml */
package:
  name: ifu

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/pcLogic.sv
      - source/instrAlign.sv
      - source/decompress.sv
      - source/stageRegs.sv
      - source/ifu.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/ifu_sva.sv
      - bench/ifu_tb.sv

/* bench/ifu_patterns.txt */
# M byte_address word | D halfword expected_expansion illegal
# B cycles_before target flag (0 branch, 1 trap, 2 branch and trap together)
M 80000000 557D0405
M 80000004 24836285
M 80000008 85B20045
M 8000000C 00952223
M 80000010 95B24144
M 80000014 C1440001
M 80000018 00500093
M 8000001C 00010001
D 0001 00000013 0
D 0405 00140413 0
D 557D FFF00513 0
D 6285 000012B7 0
D 85B2 00C005B3 0
D 95B2 00C585B3 0
D 8082 00008067 0
D 4144 00452483 0
D C144 00952223 0
D A021 0080006F 0
D C011 00040263 0
D E011 00041263 0
D 0000 00000000 1
D 8002 00008002 1
D 6105 00006105 1
B 3 80000006 0
B 2 80000011 0
B 4 80000100 1
B 2 80000002 2
B 5 80000009 0
B 1 80000000 0
